//--- sd_cmd_pkg.sv
package sd_cmd_pkg;

    localparam int CMD_ARG_W  = 32;
    localparam int CMD_IDX_W  = 6;
    localparam int FRAME_W    = 48;
    localparam int LONG_RSP_W = 136;
    localparam int RSP_W      = 120;
    localparam int CRC_W      = 7;
    localparam int NCR_MIN    = 2;
    localparam int NCR_MAX    = 64;

    // Start bit, transmission bit, index and argument
    localparam int HEAD_W     = FRAME_W - CRC_W - 1;
    // Start, transmission and reserved bits ahead of a long response body
    localparam int LONG_HDR_W = 8;
    localparam int CNT_W      = $clog2(LONG_RSP_W);

    // x^7 + x^3 + 1 with the x^7 term implied
    localparam logic [CRC_W-1:0] CRC_POLY = 7'h09;

    typedef enum logic [1:0] {
        RSP_NONE  = 2'd0,
        RSP_SHORT = 2'd1,
        RSP_LONG  = 2'd2
    } rsp_kind_e;

    typedef struct packed {
        logic [CMD_IDX_W-1:0] index;
        logic [CMD_ARG_W-1:0] argument;
        rsp_kind_e            rsp_kind;
        logic                 check_index;
        logic                 check_crc;
    } cmd_req_t;

    typedef struct packed {
        logic [HEAD_W-1:0] head;
        rsp_kind_e         rsp_kind;
    } cmd_frame_t;

    // Raw bits are right aligned, start bit of a short response at bit 47
    typedef struct packed {
        logic [LONG_RSP_W-1:0] raw;
        logic [CRC_W-1:0]      crc;
        logic                  timeout;
    } rx_word_t;

    typedef struct packed {
        logic complete;
        logic timeout_err;
        logic crc_err;
        logic index_err;
        logic end_err;
    } cmd_status_t;

    function automatic logic [CRC_W-1:0] crc7_next(
        input logic [CRC_W-1:0] crc,
        input logic             din
    );
        logic fb;
        fb = din ^ crc[CRC_W-1];
        return {crc[CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
    endfunction

endpackage

//--- sd_cmd_decode.sv
`timescale 1ns/1ns

module sd_cmd_decode (
    input  logic                             sd_clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  sd_cmd_pkg::cmd_req_t             cmd_i,
    output logic                             ack_o,
    output logic                             start_o,
    output sd_cmd_pkg::cmd_frame_t           frame_o,
    input  logic                             done_i,
    output logic [1:0]                       check_o,
    output logic [sd_cmd_pkg::CMD_IDX_W-1:0] exp_index_o
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BUSY = 2'd1,
        ST_ACK  = 2'd2
    } state_e;

    state_e   state_q;
    logic     req_q;
    logic     new_req;
    cmd_req_t cmd_q;

    // Only a fresh rising edge of req starts a command
    assign new_req = req_i && !req_q && (state_q == ST_IDLE);

    always_ff @(posedge sd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            req_q   <= 1'b0;
            start_o <= 1'b0;
        end else begin
            req_q   <= req_i;
            start_o <= new_req;
            case (state_q)
                ST_IDLE: begin
                    if (new_req) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (done_i) begin
                        state_q <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // Hold ack for as long as the host keeps req up
                    if (!req_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (new_req) begin
            cmd_q <= cmd_i;
        end
    end

    assign ack_o = (state_q == ST_ACK);

    assign frame_o = '{
        head:     {1'b0, 1'b1, cmd_q.index, cmd_q.argument},
        rsp_kind: cmd_q.rsp_kind
    };

    assign check_o     = {cmd_q.check_index, cmd_q.check_crc};
    assign exp_index_o = cmd_q.index;

endmodule

//--- sd_cmd_execute.sv
`timescale 1ns/1ns

module sd_cmd_execute (
    input  logic                   sd_clk_i,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  sd_cmd_pkg::cmd_frame_t frame_i,
    output logic                   cmd_o,
    output logic                   cmd_oe_o,
    input  logic                   cmd_i,
    output logic                   done_o,
    output sd_cmd_pkg::rx_word_t   rx_o
);
    import sd_cmd_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_TX     = 3'd1,
        ST_TURN   = 3'd2,
        ST_WAIT   = 3'd3,
        ST_RX     = 3'd4,
        ST_FINISH = 3'd5
    } state_e;

    state_e                state_q;
    rsp_kind_e             kind_q;
    logic [CNT_W-1:0]      cnt_q;
    logic                  timeout_q;
    logic [HEAD_W-1:0]     tx_shift_q;
    logic [CRC_W-1:0]      crc_q;
    logic [LONG_RSP_W-1:0] rx_shift_q;
    logic [CNT_W-1:0]      rx_last;
    logic                  covered;

    // Index of the last response bit, counting the start bit as 0
    assign rx_last = (kind_q == RSP_LONG) ? CNT_W'(LONG_RSP_W - 1) : CNT_W'(FRAME_W - 1);

    // Bits that feed the response CRC
    always_comb begin
        if (kind_q == RSP_LONG) begin
            covered = (cnt_q >= LONG_HDR_W) && (cnt_q < LONG_RSP_W - LONG_HDR_W);
        end else begin
            covered = (cnt_q < HEAD_W);
        end
    end

    always_ff @(posedge sd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            kind_q    <= RSP_NONE;
            cnt_q     <= '0;
            timeout_q <= 1'b0;
            cmd_o     <= 1'b1;
            cmd_oe_o  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q   <= ST_TX;
                        kind_q    <= frame_i.rsp_kind;
                        timeout_q <= 1'b0;
                        cmd_oe_o  <= 1'b1;
                        cmd_o     <= frame_i.head[HEAD_W-1];
                        cnt_q     <= CNT_W'(1);
                    end
                end
                ST_TX: begin
                    if (cnt_q < HEAD_W) begin
                        cmd_o <= tx_shift_q[HEAD_W-1];
                    end else if (cnt_q < FRAME_W - 1) begin
                        cmd_o <= crc_q[CRC_W-1];
                    end else begin
                        // End bit, then the line idles high
                        cmd_o <= 1'b1;
                    end
                    if (cnt_q == FRAME_W) begin
                        cmd_oe_o <= 1'b0;
                        cnt_q    <= '0;
                        state_q  <= (kind_q == RSP_NONE) ? ST_FINISH : ST_TURN;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_TURN: begin
                    if (cnt_q == NCR_MIN - 1) begin
                        cnt_q   <= '0;
                        state_q <= ST_WAIT;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (!cmd_i) begin
                        cnt_q   <= CNT_W'(1);
                        state_q <= ST_RX;
                    end else if (cnt_q == NCR_MAX - 1) begin
                        timeout_q <= 1'b1;
                        state_q   <= ST_FINISH;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_RX: begin
                    if (cnt_q == rx_last) begin
                        state_q <= ST_FINISH;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_FINISH: state_q <= ST_IDLE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (state_q == ST_IDLE && start_i) begin
            tx_shift_q <= frame_i.head << 1;
            crc_q      <= crc7_next('0, frame_i.head[HEAD_W-1]);
            rx_shift_q <= '0;
        end else if (state_q == ST_TX) begin
            if (cnt_q < HEAD_W) begin
                tx_shift_q <= tx_shift_q << 1;
                crc_q      <= crc7_next(crc_q, tx_shift_q[HEAD_W-1]);
            end else begin
                crc_q <= crc_q << 1;
            end
        end else if (state_q == ST_WAIT && !cmd_i) begin
            // A zero start bit leaves a cleared CRC unchanged
            crc_q      <= '0;
            rx_shift_q <= {rx_shift_q[LONG_RSP_W-2:0], cmd_i};
        end else if (state_q == ST_RX) begin
            rx_shift_q <= {rx_shift_q[LONG_RSP_W-2:0], cmd_i};
            if (covered) begin
                crc_q <= crc7_next(crc_q, cmd_i);
            end
        end
    end

    assign done_o = (state_q == ST_FINISH);

    assign rx_o = '{
        raw:     rx_shift_q,
        crc:     crc_q,
        timeout: timeout_q
    };

endmodule

//--- sd_cmd_result.sv
`timescale 1ns/1ns

module sd_cmd_result (
    input  logic                             sd_clk_i,
    input  logic                             rst_n_i,
    input  logic                             start_i,
    input  logic                             done_i,
    input  sd_cmd_pkg::rx_word_t             rx_i,
    input  sd_cmd_pkg::rsp_kind_e            rsp_kind_i,
    input  logic [1:0]                       check_i,
    input  logic [sd_cmd_pkg::CMD_IDX_W-1:0] exp_index_i,
    input  sd_cmd_pkg::cmd_status_t          int_en_i,
    output logic [sd_cmd_pkg::RSP_W-1:0]     rsp_o,
    output sd_cmd_pkg::cmd_status_t          status_o,
    output logic                             interrupt_o
);
    import sd_cmd_pkg::*;

    logic                 chk_index;
    logic                 chk_crc;
    logic                 has_rsp;
    logic [CRC_W-1:0]     rx_crc;
    logic [CMD_IDX_W-1:0] rx_index;
    cmd_status_t          status_d;
    logic [RSP_W-1:0]     rsp_d;

    assign {chk_index, chk_crc} = check_i;

    // Field checks only make sense when a response actually arrived
    assign has_rsp  = (rsp_kind_i != RSP_NONE) && !rx_i.timeout;
    assign rx_crc   = rx_i.raw[CRC_W:1];
    assign rx_index = rx_i.raw[FRAME_W-3 -: CMD_IDX_W];

    always_comb begin
        status_d             = '0;
        status_d.complete    = 1'b1;
        status_d.timeout_err = rx_i.timeout;
        status_d.crc_err     = has_rsp && chk_crc && (rx_crc != rx_i.crc);
        status_d.index_err   = has_rsp && chk_index && (rsp_kind_i == RSP_SHORT) &&
                               (rx_index != exp_index_i);
        status_d.end_err     = has_rsp && !rx_i.raw[0];
    end

    always_comb begin
        case (rsp_kind_i)
            RSP_SHORT: rsp_d = RSP_W'(rx_i.raw[HEAD_W-1:CRC_W+1]);
            RSP_LONG:  rsp_d = rx_i.raw[LONG_RSP_W-LONG_HDR_W-1 -: RSP_W];
            default:   rsp_d = '0;
        endcase
    end

    always_ff @(posedge sd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_o <= '0;
            rsp_o    <= '0;
        end else if (start_i) begin
            status_o <= '0;
        end else if (done_i) begin
            status_o <= status_d;
            rsp_o    <= rsp_d;
        end
    end

    assign interrupt_o = |(status_o & int_en_i);

endmodule

//--- sd_cmd_ctrl.sv
`timescale 1ns/1ns

module sd_cmd_ctrl (
    input  logic                         sd_clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  sd_cmd_pkg::cmd_req_t         cmd_i,
    output logic                         ack_o,
    output logic                         sd_cmd_o,
    input  logic                         sd_cmd_i,
    output logic                         sd_cmd_oe_o,
    input  sd_cmd_pkg::cmd_status_t      int_en_i,
    output logic [sd_cmd_pkg::RSP_W-1:0] rsp_o,
    output sd_cmd_pkg::cmd_status_t      status_o,
    output logic                         interrupt_o
);
    import sd_cmd_pkg::*;

    logic                 start;
    cmd_frame_t           frame;
    logic                 done;
    rx_word_t             rx;
    logic [1:0]           check;
    logic [CMD_IDX_W-1:0] exp_index;

    sd_cmd_decode u_decode (
        .sd_clk_i    (sd_clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .cmd_i       (cmd_i),
        .ack_o       (ack_o),
        .start_o     (start),
        .frame_o     (frame),
        .done_i      (done),
        .check_o     (check),
        .exp_index_o (exp_index)
    );

    sd_cmd_execute u_execute (
        .sd_clk_i (sd_clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start),
        .frame_i  (frame),
        .cmd_o    (sd_cmd_o),
        .cmd_oe_o (sd_cmd_oe_o),
        .cmd_i    (sd_cmd_i),
        .done_o   (done),
        .rx_o     (rx)
    );

    sd_cmd_result u_result (
        .sd_clk_i    (sd_clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (start),
        .done_i      (done),
        .rx_i        (rx),
        .rsp_kind_i  (frame.rsp_kind),
        .check_i     (check),
        .exp_index_i (exp_index),
        .int_en_i    (int_en_i),
        .rsp_o       (rsp_o),
        .status_o    (status_o),
        .interrupt_o (interrupt_o)
    );

endmodule

//--- sd_clk_gen.sv
`timescale 1ns/1ns

module sd_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // Reset held low over the first five rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- sd_cmd_ctrl_tb.sv
`timescale 1ns/1ns

module sd_cmd_ctrl_tb;
    import sd_cmd_pkg::*;

    typedef enum int {
        GOOD,
        SILENT,
        BAD_CRC,
        BAD_INDEX,
        BAD_END
    } card_mode_e;

    localparam int NUM_CMDS        = 30;
    localparam int CMD_CYCLES      = FRAME_W + NCR_MIN + NCR_MAX + LONG_RSP_W + 20;
    localparam int WATCHDOG_CYCLES = NUM_CMDS * CMD_CYCLES + 20;

    logic                  clk;
    logic                  rst_n;
    logic                  req_i;
    cmd_req_t              cmd_i;
    logic                  ack_o;
    logic                  sd_cmd_o;
    logic                  sd_cmd_i;
    logic                  sd_cmd_oe_o;
    cmd_status_t           int_en_i;
    logic [RSP_W-1:0]      rsp_o;
    cmd_status_t           status_o;
    logic                  interrupt_o;

    logic [31:0]           seed;
    logic                  cur_respond;
    logic [LONG_RSP_W-1:0] cur_rsp;
    int                    cur_delay;
    logic [FRAME_W-1:0]    cap_frame;
    int                    cap_len;
    logic [FRAME_W-1:0]    exp_frame;
    cmd_status_t           exp_status;
    logic [RSP_W-1:0]      exp_rsp;
    logic                  exp_rsp_valid;
    logic                  exp_irq;
    logic                  ack_prev = 1'b0;
    int                    checked = 0;

    sd_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    sd_cmd_ctrl UUT (
        .sd_clk_i    (clk),
        .rst_n_i     (rst_n),
        .req_i       (req_i),
        .cmd_i       (cmd_i),
        .ack_o       (ack_o),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_i    (sd_cmd_i),
        .sd_cmd_oe_o (sd_cmd_oe_o),
        .int_en_i    (int_en_i),
        .rsp_o       (rsp_o),
        .status_o    (status_o),
        .interrupt_o (interrupt_o)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] rand32();
        seed = lcg_step(seed);
        return seed;
    endfunction

    // Serial CRC7, x^7 + x^3 + 1, over data[n-1] down to data[0]
    function automatic logic [CRC_W-1:0] calc_crc7(input logic [LONG_RSP_W-1:0] data,
                                                   input int n);
        logic [CRC_W-1:0] c;
        logic             fb;
        int               i;
        c = '0;
        for (i = n - 1; i >= 0; i--) begin
            fb = data[i] ^ c[CRC_W-1];
            c  = {c[CRC_W-2:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    function automatic logic [FRAME_W-1:0] build_frame(input cmd_req_t c);
        logic [HEAD_W-1:0] head;
        head = {1'b0, 1'b1, c.index, c.argument};
        return {head, calc_crc7(head, HEAD_W), 1'b1};
    endfunction

    // Card response, right aligned, with the chosen defect applied
    function automatic logic [LONG_RSP_W-1:0] build_response(input rsp_kind_e kind,
            input card_mode_e mode, input logic [CMD_IDX_W-1:0] index,
            input logic [RSP_W-1:0] payload, input int flip);
        logic [LONG_RSP_W-1:0] r;
        logic [HEAD_W-1:0]     head;
        r = '0;
        if (kind == RSP_LONG) begin
            r = {2'b00, 6'h3f, payload, calc_crc7(payload, RSP_W), 1'b1};
        end else begin
            head             = {2'b00, index, payload[CMD_ARG_W-1:0]};
            r[FRAME_W-1:0]   = {head, calc_crc7(head, HEAD_W), 1'b1};
        end
        if (mode == BAD_CRC) begin
            r[1 + flip] = ~r[1 + flip];
        end
        if (mode == BAD_END) begin
            r[0] = 1'b0;
        end
        return r;
    endfunction

    function automatic logic [RSP_W-1:0] expected_rsp(input rsp_kind_e kind,
                                                      input logic [RSP_W-1:0] payload);
        if (kind == RSP_LONG) begin
            return payload;
        end
        return {{(RSP_W - CMD_ARG_W){1'b0}}, payload[CMD_ARG_W-1:0]};
    endfunction

    function automatic cmd_status_t expected_status(input cmd_req_t c, input card_mode_e mode);
        cmd_status_t s;
        s          = '0;
        s.complete = 1'b1;
        if (c.rsp_kind == RSP_NONE) begin
            return s;
        end
        if (mode == SILENT) begin
            s.timeout_err = 1'b1;
            return s;
        end
        s.crc_err   = c.check_crc && (mode == BAD_CRC);
        s.index_err = c.check_index && (c.rsp_kind == RSP_SHORT) && (mode == BAD_INDEX);
        s.end_err   = (mode == BAD_END);
        return s;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic status_check(input string name, input cmd_status_t got,
                                input cmd_status_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic rsp_check(input string name, input logic [RSP_W-1:0] got,
                             input logic [RSP_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic frame_check(input string name, input logic [FRAME_W-1:0] got,
                               input logic [FRAME_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic bit_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic wait_ack(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ack_o !== level) begin
            if (cycles == limit) begin
                stop_on_error($sformatf("Handshake stalled, ack_o did not %s within %0d cycles",
                                        what, limit));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic run_cmd(input rsp_kind_e kind, input card_mode_e mode,
                           input logic chk_idx, input logic chk_crc);
        cmd_req_t             c;
        cmd_status_t          en;
        logic [127:0]         wide;
        logic [RSP_W-1:0]     payload;
        logic [CMD_IDX_W-1:0] rsp_index;
        logic [31:0]          r;
        int                   flip;
        int                   hold;
        int                   j;
        r             = rand32();
        c.index       = r[CMD_IDX_W-1:0];
        c.argument    = rand32();
        c.rsp_kind    = kind;
        c.check_index = chk_idx;
        c.check_crc   = chk_crc;
        en            = cmd_status_t'(r[12:8]);
        wide          = {rand32(), rand32(), rand32(), rand32()};
        payload       = wide[RSP_W-1:0];
        rsp_index     = c.index;
        if (mode == BAD_INDEX) begin
            rsp_index = c.index ^ (CMD_IDX_W'(1) + CMD_IDX_W'(rand32() % 63));
        end
        flip      = rand32() % CRC_W;
        hold      = 1 + rand32() % 3;
        cur_delay = NCR_MIN + rand32() % (NCR_MAX - NCR_MIN);

        cur_respond   = (kind != RSP_NONE) && (mode != SILENT);
        cur_rsp       = build_response(kind, mode, rsp_index, payload, flip);
        exp_frame     = build_frame(c);
        exp_status    = expected_status(c, mode);
        exp_rsp       = expected_rsp(kind, payload);
        exp_rsp_valid = cur_respond;
        exp_irq       = |(exp_status & en);

        @(posedge clk);
        cmd_i    <= c;
        int_en_i <= en;
        req_i    <= 1'b1;
        wait_ack(1'b1, CMD_CYCLES, "rise after the request");

        // Host keeps req up for a while, ack must hold and CMD stay idle
        for (j = 0; j < hold; j++) begin
            @(negedge clk);
            bit_check("ack_o", ack_o, 1'b1);
            bit_check("sd_cmd_oe_o", sd_cmd_oe_o, 1'b0);
        end
        @(posedge clk);
        req_i <= 1'b0;
        wait_ack(1'b0, 4, "fall after req_i was lowered");
    endtask

    // Card model
    initial begin : card
        logic [FRAME_W-1:0] bits;
        int                 n;
        int                 len;
        int                 i;
        sd_cmd_i = 1'b1;
        bits     = '0;
        forever begin
            n = 0;
            @(negedge clk);
            while (sd_cmd_oe_o !== 1'b1) @(negedge clk);
            while (sd_cmd_oe_o === 1'b1) begin
                bits = {bits[FRAME_W-2:0], sd_cmd_o};
                n++;
                @(negedge clk);
            end
            cap_frame = bits;
            cap_len   = n;
            if (cur_respond) begin
                len = (cmd_i.rsp_kind == RSP_LONG) ? LONG_RSP_W : FRAME_W;
                repeat (cur_delay) @(posedge clk);
                for (i = len - 1; i >= 0; i--) begin
                    sd_cmd_i <= cur_rsp[i];
                    @(posedge clk);
                end
                sd_cmd_i <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin : result_compare
        if (rst_n && ack_o && !ack_prev) begin
            if (cap_len != FRAME_W) begin
                stop_on_error($sformatf("Command frame had %0d bits instead of %0d",
                                        cap_len, FRAME_W));
            end
            frame_check("sd_cmd_o frame", cap_frame, exp_frame);
            status_check("status_o", status_o, exp_status);
            if (exp_rsp_valid) begin
                rsp_check("rsp_o", rsp_o, exp_rsp);
            end
            bit_check("interrupt_o", interrupt_o, exp_irq);
            checked++;
        end
        ack_prev = ack_o;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error("Watchdog expired before all commands finished");
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] k;
        req_i    = 1'b0;
        cmd_i    = '0;
        int_en_i = '0;
        seed     = 32'hd0bc_77c1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        bit_check("ack_o", ack_o, 1'b0);
        bit_check("sd_cmd_oe_o", sd_cmd_oe_o, 1'b0);
        bit_check("sd_cmd_o", sd_cmd_o, 1'b1);
        bit_check("interrupt_o", interrupt_o, 1'b0);
        status_check("status_o", status_o, '0);
        rsp_check("rsp_o", rsp_o, '0);

        repeat (4) run_cmd(RSP_SHORT, GOOD, 1'b1, 1'b1);
        repeat (3) run_cmd(RSP_LONG, GOOD, 1'b0, 1'b1);
        run_cmd(RSP_LONG, BAD_CRC, 1'b0, 1'b1);
        run_cmd(RSP_LONG, BAD_CRC, 1'b0, 1'b0);
        run_cmd(RSP_SHORT, BAD_CRC, 1'b1, 1'b1);
        run_cmd(RSP_SHORT, BAD_INDEX, 1'b1, 1'b1);
        run_cmd(RSP_SHORT, BAD_INDEX, 1'b0, 1'b1);
        run_cmd(RSP_SHORT, BAD_END, 1'b1, 1'b1);
        run_cmd(RSP_SHORT, SILENT, 1'b1, 1'b1);
        run_cmd(RSP_LONG, SILENT, 1'b0, 1'b1);
        repeat (2) run_cmd(RSP_NONE, GOOD, 1'b0, 1'b0);
        repeat (NUM_CMDS - 17) begin
            r = rand32();
            k = rand32();
            run_cmd(rsp_kind_e'(2'(r % 3)), card_mode_e'(k % 5), r[8], r[9]);
        end

        if (checked != NUM_CMDS) begin
            stop_on_error($sformatf("Only %0d of %0d acknowledged commands were checked",
                                    checked, NUM_CMDS));
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- sd_cmd_ctrl.f
sd_cmd_pkg.sv
sd_cmd_decode.sv
sd_cmd_execute.sv
sd_cmd_result.sv
sd_cmd_ctrl.sv
sd_clk_gen.sv
sd_cmd_ctrl_tb.sv

//--- Bender.yml
package:
  name: sd_cmd_ctrl

sources:
  - files:
      - sd_cmd_pkg.sv
      - sd_cmd_decode.sv
      - sd_cmd_execute.sv
      - sd_cmd_result.sv
      - sd_cmd_ctrl.sv
  - target: test
    files:
      - sd_clk_gen.sv
      - sd_cmd_ctrl_tb.sv
